// File: common/core_pkg.sv
package core_pkg;

	typedef enum logic [3:0] {
		ADDI,
		ADD,
		SUB,
		LD,
		ST,
		BEQ,
		CSRWR,
		HALT
	} opcode_e;

	// rd <- rs1 op rs2 / imm, imm is sign extended except for CSRWR
	typedef struct packed {
		opcode_e     opcode;
		logic [2:0]  rd;
		logic [2:0]  rs1;
		logic [2:0]  rs2;
		logic [18:0] imm;
	} inst_t;

	typedef struct packed {
		logic        req;
		logic        we;
		logic [31:0] addr;
		logic [31:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] rdata;
	} bus_resp_t;

	// one direct mapped window, segment is addr[31:29]
	typedef struct packed {
		logic       en;
		logic [2:0] vseg;
		logic [2:0] pseg;
	} dmw_t;

	typedef struct packed {
		logic da;
		dmw_t dmw0;
		dmw_t dmw1;
	} csr_state_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] target;
	} redirect_t;

	typedef struct packed {
		logic [31:0] paddr;
		logic        fault;
	} mmu_resp_t;

	// CSRWR target, taken from imm[1:0]
	typedef enum logic [1:0] {
		CRMD,
		DMW0,
		DMW1
	} csr_sel_e;

endpackage

// File: rtl/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter (
	input  logic                clk,
	input  logic                rst_n_i,
	input  core_pkg::bus_req_t  ibus_req_i,
	output core_pkg::bus_resp_t ibus_resp_o,
	input  core_pkg::bus_req_t  dbus_req_i,
	output core_pkg::bus_resp_t dbus_resp_o,
	output core_pkg::bus_req_t  mem_req_o,
	input  core_pkg::bus_resp_t mem_resp_i
);

	typedef enum logic [1:0] {
		IDLE,
		GRANT_I,
		GRANT_D
	} grant_e;

	grant_e             state_q;
	core_pkg::bus_req_t mem_req_q;
	core_pkg::bus_req_t owner_req;

	assign owner_req = (state_q == GRANT_D) ? dbus_req_i : ibus_req_i;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q   <= IDLE;
			mem_req_q <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					// data side first
					if (dbus_req_i.req) begin
						state_q   <= GRANT_D;
						mem_req_q <= dbus_req_i;
					end else if (ibus_req_i.req) begin
						state_q   <= GRANT_I;
						mem_req_q <= ibus_req_i;
					end
				end
				default: begin
					if (mem_req_q.req) begin
						mem_req_q <= owner_req;
					end else if (!mem_resp_i.ack) begin
						state_q <= IDLE;
					end
				end
			endcase
		end
	end

	assign mem_req_o = mem_req_q;

	assign ibus_resp_o.ack   = (state_q == GRANT_I) && mem_resp_i.ack;
	assign ibus_resp_o.rdata = (state_q == GRANT_I) ? mem_resp_i.rdata : '0;
	assign dbus_resp_o.ack   = (state_q == GRANT_D) && mem_resp_i.ack;
	assign dbus_resp_o.rdata = (state_q == GRANT_D) ? mem_resp_i.rdata : '0;

endmodule

// File: frontend/frontend.sv
`timescale 1ns/1ns

module frontend #(
	parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
	input  logic                clk,
	input  logic                rst_n_i,
	output core_pkg::bus_req_t  bus_req_o,
	input  core_pkg::bus_resp_t bus_resp_i,
	output logic [31:0]         mmu_vaddr_o,
	input  core_pkg::mmu_resp_t mmu_resp_i,
	output core_pkg::inst_t     inst_o,
	output logic                inst_valid_o,
	output logic                inst_fault_o,
	input  logic                inst_ready_i,
	input  core_pkg::redirect_t redirect_i
);

	typedef enum logic [1:0] {
		IDLE,
		WAIT_ACK,
		WAIT_DROP
	} fetch_e;

	fetch_e          state_q;
	logic [31:0]     pc_q;
	logic [31:0]     addr_q;
	core_pkg::inst_t buf_q;
	logic            buf_valid_q;
	logic            buf_fault_q;
	logic            discard_q;
	logic            start_fetch;
	logic            fetch_ok;
	logic            fetch_fault;
	logic            fill;

	// buffer free or handed over this cycle; stale pc during a redirect
	assign start_fetch = (state_q == IDLE) && (!buf_valid_q || inst_ready_i)
		&& !redirect_i.valid;
	assign fetch_ok    = start_fetch && !mmu_resp_i.fault;
	assign fetch_fault = start_fetch && mmu_resp_i.fault;
	assign fill        = (state_q == WAIT_ACK) && bus_resp_i.ack && !discard_q;

	always_ff @(posedge clk) begin
		if (fetch_ok) begin
			addr_q <= mmu_resp_i.paddr;
		end
		if (fill) begin
			buf_q <= core_pkg::inst_t'(bus_resp_i.rdata);
		end else if (fetch_fault) begin
			buf_q <= '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q     <= IDLE;
			pc_q        <= RESET_PC;
			buf_valid_q <= 1'b0;
			buf_fault_q <= 1'b0;
			discard_q   <= 1'b0;
		end else begin
			if (buf_valid_q && inst_ready_i) begin
				buf_valid_q <= 1'b0;
			end
			if (fill) begin
				buf_valid_q <= 1'b1;
				buf_fault_q <= 1'b0;
				pc_q        <= pc_q + 32'd4;
			end
			// faulting fetch goes to the backend with no bus cycle
			if (fetch_fault) begin
				buf_valid_q <= 1'b1;
				buf_fault_q <= 1'b1;
			end
			case (state_q)
				IDLE: begin
					if (fetch_ok) begin
						state_q   <= WAIT_ACK;
						discard_q <= 1'b0;
					end
				end
				WAIT_ACK: begin
					if (bus_resp_i.ack) begin
						state_q <= WAIT_DROP;
					end
				end
				WAIT_DROP: begin
					if (!bus_resp_i.ack) begin
						state_q <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
			if (redirect_i.valid) begin
				pc_q        <= redirect_i.target;
				buf_valid_q <= 1'b0;
				if (state_q == WAIT_ACK) begin
					discard_q <= 1'b1;
				end
			end
		end
	end

	assign mmu_vaddr_o = pc_q;

	assign bus_req_o.req   = (state_q == WAIT_ACK);
	assign bus_req_o.we    = 1'b0;
	assign bus_req_o.addr  = addr_q;
	assign bus_req_o.wdata = '0;

	assign inst_o       = buf_q;
	assign inst_valid_o = buf_valid_q;
	assign inst_fault_o = buf_fault_q;

endmodule

// File: backend/backend.sv
`timescale 1ns/1ns

module backend #(
	parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  core_pkg::inst_t      inst_i,
	input  logic                 inst_valid_i,
	input  logic                 inst_fault_i,
	output logic                 inst_ready_o,
	output core_pkg::redirect_t  redirect_o,
	output core_pkg::csr_state_t csr_o,
	output core_pkg::bus_req_t   bus_req_o,
	input  core_pkg::bus_resp_t  bus_resp_i,
	output logic [31:0]          mmu_vaddr_o,
	input  core_pkg::mmu_resp_t  mmu_resp_i,
	output logic                 halt_o,
	output logic                 fault_o
);

	typedef enum logic [1:0] {
		RUN,
		MEM_WAIT,
		MEM_DROP,
		STOP
	} state_e;

	state_e               state_q;
	core_pkg::inst_t      ex_q;
	logic                 ex_valid_q;
	logic                 ex_fault_q;
	logic [31:0]          pc_q;
	core_pkg::csr_state_t csr_q;
	core_pkg::bus_req_t   bus_q;
	logic                 halt_q;
	logic                 fault_q;
	logic [31:0]          rf_q [8];
	logic [31:0]          rs1_val, rs2_val, imm_sx;
	logic                 ex_go;
	logic                 taken;
	logic                 rf_we;
	logic [31:0]          rf_wdata;

	// one instruction in flight, next is taken once it retires
	assign inst_ready_o = (state_q == RUN) && !ex_valid_q;
	assign ex_go        = ex_valid_q && (state_q == RUN) && !ex_fault_q;

	assign rs1_val = (ex_q.rs1 == 3'd0) ? 32'd0 : rf_q[ex_q.rs1];
	assign rs2_val = (ex_q.rs2 == 3'd0) ? 32'd0 : rf_q[ex_q.rs2];
	assign imm_sx  = {{13{ex_q.imm[18]}}, ex_q.imm};

	// branch target is relative to the BEQ itself
	assign taken = ex_go && (ex_q.opcode == core_pkg::BEQ) && (rs1_val == rs2_val);
	assign redirect_o.valid  = taken;
	assign redirect_o.target = pc_q + {imm_sx[29:0], 2'b00};

	assign mmu_vaddr_o = rs1_val + imm_sx;

	always_comb begin
		rf_we    = 1'b0;
		rf_wdata = '0;
		if ((state_q == MEM_WAIT) && bus_resp_i.ack && !bus_q.we) begin
			rf_we    = 1'b1;
			rf_wdata = bus_resp_i.rdata;
		end else if (ex_go) begin
			case (ex_q.opcode)
				core_pkg::ADDI: begin
					rf_we    = 1'b1;
					rf_wdata = rs1_val + imm_sx;
				end
				core_pkg::ADD: begin
					rf_we    = 1'b1;
					rf_wdata = rs1_val + rs2_val;
				end
				core_pkg::SUB: begin
					rf_we    = 1'b1;
					rf_wdata = rs1_val - rs2_val;
				end
				default: rf_we = 1'b0;
			endcase
		end
	end

	// r0 is never written
	always_ff @(posedge clk) begin
		if (rf_we && (ex_q.rd != 3'd0)) begin
			rf_q[ex_q.rd] <= rf_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (inst_valid_i && inst_ready_o) begin
			ex_q <= inst_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q    <= RUN;
			ex_valid_q <= 1'b0;
			ex_fault_q <= 1'b0;
			pc_q       <= RESET_PC;
			csr_q      <= '0;
			csr_q.da   <= 1'b1;
			bus_q      <= '0;
			halt_q     <= 1'b0;
			fault_q    <= 1'b0;
		end else begin
			case (state_q)
				RUN: begin
					if (ex_valid_q) begin
						ex_valid_q <= 1'b0;
						pc_q       <= taken ? redirect_o.target : pc_q + 32'd4;
						if (ex_fault_q) begin
							state_q <= STOP;
							fault_q <= 1'b1;
						end else begin
							case (ex_q.opcode)
								core_pkg::HALT: begin
									state_q <= STOP;
									halt_q  <= 1'b1;
								end
								core_pkg::LD, core_pkg::ST: begin
									if (mmu_resp_i.fault) begin
										state_q <= STOP;
										fault_q <= 1'b1;
									end else begin
										state_q     <= MEM_WAIT;
										bus_q.req   <= 1'b1;
										bus_q.we    <= (ex_q.opcode == core_pkg::ST);
										bus_q.addr  <= mmu_resp_i.paddr;
										bus_q.wdata <= rs2_val;
									end
								end
								core_pkg::CSRWR: begin
									case (core_pkg::csr_sel_e'(ex_q.imm[1:0]))
										core_pkg::CRMD: csr_q.da <= rs1_val[0];
										core_pkg::DMW0: csr_q.dmw0 <= core_pkg::dmw_t'(rs1_val[6:0]);
										core_pkg::DMW1: csr_q.dmw1 <= core_pkg::dmw_t'(rs1_val[6:0]);
										default: csr_q <= csr_q;
									endcase
								end
								default: state_q <= RUN;
							endcase
						end
					end else if (inst_valid_i) begin
						ex_valid_q <= 1'b1;
						ex_fault_q <= inst_fault_i;
					end
				end
				MEM_WAIT: begin
					if (bus_resp_i.ack) begin
						bus_q.req <= 1'b0;
						state_q   <= MEM_DROP;
					end
				end
				MEM_DROP: begin
					if (!bus_resp_i.ack) begin
						state_q <= RUN;
					end
				end
				default: state_q <= STOP;
			endcase
		end
	end

	assign csr_o     = csr_q;
	assign bus_req_o = bus_q;
	assign halt_o    = halt_q;
	assign fault_o   = fault_q;

endmodule

// File: mmu/mmu.sv
`timescale 1ns/1ns

module mmu (
	input  logic [31:0]          fetch_vaddr_i,
	output core_pkg::mmu_resp_t  fetch_resp_o,
	input  logic [31:0]          data_vaddr_i,
	output core_pkg::mmu_resp_t  data_resp_o,
	input  core_pkg::csr_state_t csr_i
);

	// dmw0 checked first, only the segment bits change
	function automatic core_pkg::mmu_resp_t translate(
		input logic [31:0]          vaddr,
		input core_pkg::csr_state_t csr
	);
		core_pkg::mmu_resp_t resp;
		resp.paddr = vaddr;
		resp.fault = 1'b0;
		if (!csr.da) begin
			if (csr.dmw0.en && (vaddr[31:29] == csr.dmw0.vseg)) begin
				resp.paddr[31:29] = csr.dmw0.pseg;
			end else if (csr.dmw1.en && (vaddr[31:29] == csr.dmw1.vseg)) begin
				resp.paddr[31:29] = csr.dmw1.pseg;
			end else begin
				resp.fault = 1'b1;
			end
		end
		return resp;
	endfunction

	assign fetch_resp_o = translate(fetch_vaddr_i, csr_i);
	assign data_resp_o  = translate(data_vaddr_i, csr_i);

endmodule

// File: rtl/core.sv
`timescale 1ns/1ns

module core #(
	parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
	input  logic                clk,
	input  logic                rst_n_i,
	output core_pkg::bus_req_t  mem_req_o,
	input  core_pkg::bus_resp_t mem_resp_i,
	output logic                halt_o,
	output logic                fault_o
);

	core_pkg::inst_t      inst;
	logic                 inst_valid;
	logic                 inst_fault;
	logic                 inst_ready;
	core_pkg::redirect_t  redirect;
	core_pkg::csr_state_t csr;
	core_pkg::bus_req_t   ibus_req, dbus_req;
	core_pkg::bus_resp_t  ibus_resp, dbus_resp;
	logic [31:0]          fetch_vaddr, data_vaddr;
	core_pkg::mmu_resp_t  immu_resp, dmmu_resp;

	bus_arbiter bus_arbiter (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.ibus_req_i  (ibus_req),
		.ibus_resp_o (ibus_resp),
		.dbus_req_i  (dbus_req),
		.dbus_resp_o (dbus_resp),
		.mem_req_o   (mem_req_o),
		.mem_resp_i  (mem_resp_i)
	);

	frontend #(
		.RESET_PC(RESET_PC)
	) frontend (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.bus_req_o    (ibus_req),
		.bus_resp_i   (ibus_resp),
		.mmu_vaddr_o  (fetch_vaddr),
		.mmu_resp_i   (immu_resp),
		.inst_o       (inst),
		.inst_valid_o (inst_valid),
		.inst_fault_o (inst_fault),
		.inst_ready_i (inst_ready),
		.redirect_i   (redirect)
	);

	backend #(
		.RESET_PC(RESET_PC)
	) backend (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.inst_i       (inst),
		.inst_valid_i (inst_valid),
		.inst_fault_i (inst_fault),
		.inst_ready_o (inst_ready),
		.redirect_o   (redirect),
		.csr_o        (csr),
		.bus_req_o    (dbus_req),
		.bus_resp_i   (dbus_resp),
		.mmu_vaddr_o  (data_vaddr),
		.mmu_resp_i   (dmmu_resp),
		.halt_o       (halt_o),
		.fault_o      (fault_o)
	);

	mmu mmu (
		.fetch_vaddr_i (fetch_vaddr),
		.fetch_resp_o  (immu_resp),
		.data_vaddr_i  (data_vaddr),
		.data_resp_o   (dmmu_resp),
		.csr_i         (csr)
	);

endmodule

// File: test/core_checker.sv
`timescale 1ns/1ns

module core_checker (
	input logic                clk,
	input logic                rst_n_i,
	input core_pkg::bus_req_t  mem_req_i,
	input core_pkg::bus_resp_t mem_resp_i,
	input logic                halt_i
);

	// new request only once the last ack is gone
	assert property (@(posedge clk) disable iff (!rst_n_i)
		$rose(mem_req_i.req) |-> !mem_resp_i.ack)
	else $error("memory req raised while ack high");

	assert property (@(posedge clk) disable iff (!rst_n_i)
		mem_req_i.req && $past(mem_req_i.req) |-> mem_req_i.addr == $past(mem_req_i.addr))
	else $error("memory addr changed during req");

	assert property (@(posedge clk) disable iff (!rst_n_i)
		$rose(mem_resp_i.ack) |-> mem_req_i.req)
	else $error("memory ack without req");

	assert property (@(posedge clk) disable iff (!rst_n_i)
		!$fell(halt_i))
	else $error("halt dropped");

endmodule

bind core core_checker core_checker_i (
	.clk        (clk),
	.rst_n_i    (rst_n_i),
	.mem_req_i  (mem_req_o),
	.mem_resp_i (mem_resp_i),
	.halt_i     (halt_o)
);

// File: test/tb_core.sv
`timescale 1ns/1ns

module tb_core;

	localparam logic [31:0] RESET_PC = 32'h1c00_0000;

	logic                clk;
	logic                rst_n;
	core_pkg::bus_req_t  mem_req;
	core_pkg::bus_resp_t mem_resp;
	logic                halt;
	logic                fault;

	logic [31:0]        mem [logic [31:0]];
	logic [31:0]        ref_mem [logic [31:0]];
	logic [31:0]        prog [$];
	logic [31:0]        exp_addr [$];
	logic [31:0]        exp_data [$];
	core_pkg::bus_req_t writes [$];
	int                 store_idx;
	int                 wait_cnt;
	bit                 slow_mem;
	bit                 timed_out;
	int                 errors;
	int                 checks;

	core #(
		.RESET_PC(RESET_PC)
	) dut_i (
		.clk        (clk),
		.rst_n_i    (rst_n),
		.mem_req_o  (mem_req),
		.mem_resp_i (mem_resp),
		.halt_o     (halt),
		.fault_o    (fault)
	);

	always #4 clk = ~clk;

	function automatic int next_delay();
		if (slow_mem) begin
			return int'($urandom_range(7, 4));
		end
		return int'($urandom_range(3, 0));
	endfunction

	// four-phase memory that acks after a random delay
	always @(posedge clk) begin
		if (!rst_n) begin
			mem_resp <= '0;
			wait_cnt <= 0;
		end else if (mem_req.req && !mem_resp.ack) begin
			if (wait_cnt == 0) begin
				mem_resp.ack   <= 1'b1;
				mem_resp.rdata <= mem.exists(mem_req.addr) ? mem[mem_req.addr] : 32'h0;
				if (mem_req.we) begin
					mem[mem_req.addr] = mem_req.wdata;
					writes.push_back(mem_req);
				end
				wait_cnt <= next_delay();
			end else begin
				wait_cnt <= wait_cnt - 1;
			end
		end else if (!mem_req.req && mem_resp.ack) begin
			mem_resp.ack <= 1'b0;
		end
	end

	// every external write against the next expected store
	always @(posedge clk) begin
		core_pkg::bus_req_t w;
		if (writes.size() > 0) begin
			w = writes.pop_front();
			checks++;
			assert (store_idx < exp_addr.size() && w.addr == exp_addr[store_idx]
				&& w.wdata == exp_data[store_idx])
			else begin
				errors++;
				$display("Error %0t: store %0d wrote %h to %h, expected store list has %0d entries",
					$time, store_idx, w.wdata, w.addr, exp_addr.size());
			end
			store_idx++;
		end
	end

	function automatic logic [31:0] encode(input core_pkg::opcode_e op, input int rd,
		input int rs1, input int rs2, input int imm);
		return {op, rd[2:0], rs1[2:0], rs2[2:0], imm[18:0]};
	endfunction

	task automatic put(input core_pkg::opcode_e op, input int rd, input int rs1,
		input int rs2, input int imm);
		prog.push_back(encode(op, rd, rs1, rs2, imm));
	endtask

	task automatic preload(input logic [31:0] addr, input logic [31:0] data);
		mem[addr]     = data;
		ref_mem[addr] = data;
	endtask

	function automatic logic [31:0] ref_read(input logic [31:0] addr);
		return ref_mem.exists(addr) ? ref_mem[addr] : 32'h0;
	endfunction

	// returns 1 when no window covers the address
	function automatic bit ref_xlat(input logic [31:0] va, input bit da, input logic [6:0] w0,
		input logic [6:0] w1, output logic [31:0] pa);
		pa = va;
		if (da) begin
			return 1'b0;
		end
		if (w0[6] && va[31:29] == w0[5:3]) begin
			pa[31:29] = w0[2:0];
			return 1'b0;
		end
		if (w1[6] && va[31:29] == w1[5:3]) begin
			pa[31:29] = w1[2:0];
			return 1'b0;
		end
		return 1'b1;
	endfunction

	// ISA model that fills the expected stores and returns 1 on a fault
	function automatic bit ref_run();
		logic [31:0] regs [8];
		logic [31:0] pc, pa, word, a, b, sx, nxt;
		logic [6:0]  w0, w1;
		bit          da;
		regs = '{default: 32'h0};
		pc   = RESET_PC;
		da   = 1'b1;
		w0   = '0;
		w1   = '0;
		for (int n = 0; n < 4096; n++) begin
			if (ref_xlat(pc, da, w0, w1, pa)) begin
				return 1'b1;
			end
			word = ref_read(pa);
			a    = regs[word[24:22]];
			b    = regs[word[21:19]];
			sx   = {{13{word[18]}}, word[18:0]};
			nxt  = pc + 32'd4;
			case (word[31:28])
				core_pkg::ADDI: regs[word[27:25]] = a + sx;
				core_pkg::ADD: regs[word[27:25]] = a + b;
				core_pkg::SUB: regs[word[27:25]] = a - b;
				core_pkg::LD: begin
					if (ref_xlat(a + sx, da, w0, w1, pa)) begin
						return 1'b1;
					end
					regs[word[27:25]] = ref_read(pa);
				end
				core_pkg::ST: begin
					if (ref_xlat(a + sx, da, w0, w1, pa)) begin
						return 1'b1;
					end
					ref_mem[pa] = b;
					exp_addr.push_back(pa);
					exp_data.push_back(b);
				end
				core_pkg::BEQ: begin
					if (a == b) begin
						nxt = pc + (sx << 2);
					end
				end
				core_pkg::CSRWR: begin
					case (word[1:0])
						2'd0: da = a[0];
						2'd1: w0 = a[6:0];
						2'd2: w1 = a[6:0];
						default: da = da;
					endcase
				end
				core_pkg::HALT: return 1'b0;
				default: nxt = pc + 32'd4;
			endcase
			regs[0] = 32'h0;
			pc      = nxt;
		end
		return 1'b0;
	endfunction

	task automatic build(input int which);
		prog.delete();
		case (which)
			// alu, r0, loads and stores, branches
			0: begin
				preload(32'h200, 32'h1234_5678);
				put(core_pkg::ADDI, 1, 0, 0, 5);
				put(core_pkg::ADDI, 2, 0, 0, -3);
				put(core_pkg::ADD, 3, 1, 2, 0);
				put(core_pkg::SUB, 4, 1, 2, 0);
				put(core_pkg::ADDI, 0, 1, 0, 7);
				put(core_pkg::ADDI, 5, 0, 0, 'h100);
				put(core_pkg::ST, 0, 5, 3, 0);
				put(core_pkg::ST, 0, 5, 4, 4);
				put(core_pkg::ST, 0, 5, 0, 8);
				put(core_pkg::LD, 6, 0, 0, 'h200);
				put(core_pkg::ADD, 7, 6, 1, 0);
				put(core_pkg::ST, 0, 5, 7, 12);
				put(core_pkg::LD, 6, 5, 0, 4);
				put(core_pkg::SUB, 7, 6, 2, 0);
				put(core_pkg::ST, 0, 5, 7, 16);
				put(core_pkg::BEQ, 0, 1, 1, 2);
				put(core_pkg::ST, 0, 5, 1, 20);
				put(core_pkg::BEQ, 0, 1, 2, 2);
				put(core_pkg::ST, 0, 5, 2, 24);
				put(core_pkg::HALT, 0, 0, 0, 0);
			end
			// seg 0 kept identity, seg 5 to seg 2, then dmw1 also on seg 0
			1: begin
				preload(32'h300, 32'ha000_0400);
				put(core_pkg::ADDI, 1, 0, 0, 'h40);
				put(core_pkg::CSRWR, 0, 1, 0, 1);
				put(core_pkg::ADDI, 1, 0, 0, 'h6a);
				put(core_pkg::CSRWR, 0, 1, 0, 2);
				put(core_pkg::CSRWR, 0, 0, 0, 0);
				put(core_pkg::ADDI, 2, 0, 0, 'h55);
				put(core_pkg::LD, 3, 0, 0, 'h300);
				put(core_pkg::ST, 0, 3, 2, 0);
				put(core_pkg::ST, 0, 3, 3, 4);
				put(core_pkg::ADDI, 1, 0, 0, 'h43);
				put(core_pkg::CSRWR, 0, 1, 0, 2);
				put(core_pkg::ST, 0, 0, 2, 'h180);
				put(core_pkg::HALT, 0, 0, 0, 0);
			end
			// store to unmapped seg 7
			2: begin
				preload(32'h304, 32'he000_0000);
				put(core_pkg::ADDI, 1, 0, 0, 'h40);
				put(core_pkg::CSRWR, 0, 1, 0, 1);
				put(core_pkg::CSRWR, 0, 0, 0, 0);
				put(core_pkg::ADDI, 2, 0, 0, 9);
				put(core_pkg::ST, 0, 0, 2, 'h100);
				put(core_pkg::LD, 3, 0, 0, 'h304);
				put(core_pkg::ST, 0, 3, 2, 0);
				put(core_pkg::ST, 0, 0, 2, 'h104);
				put(core_pkg::HALT, 0, 0, 0, 0);
			end
			// code window removed so the branch target fetch faults
			default: begin
				put(core_pkg::ADDI, 1, 0, 0, 'h40);
				put(core_pkg::CSRWR, 0, 1, 0, 1);
				put(core_pkg::CSRWR, 0, 0, 0, 0);
				put(core_pkg::ADDI, 2, 0, 0, 3);
				put(core_pkg::ST, 0, 0, 2, 'h100);
				put(core_pkg::CSRWR, 0, 0, 0, 1);
				put(core_pkg::BEQ, 0, 0, 0, 2);
				put(core_pkg::ST, 0, 0, 2, 'h104);
				put(core_pkg::ST, 0, 0, 2, 'h108);
				put(core_pkg::HALT, 0, 0, 0, 0);
			end
		endcase
	endtask

	task automatic run_prog(input int which, input bit slow);
		bit exp_fault;
		int limit;
		int cycles;
		if (timed_out) begin
			return;
		end
		@(posedge clk);
		rst_n <= 1'b0;
		@(posedge clk);
		mem.delete();
		ref_mem.delete();
		exp_addr.delete();
		exp_data.delete();
		writes.delete();
		store_idx = 0;
		slow_mem  = slow;
		build(which);
		foreach (prog[i]) begin
			preload(RESET_PC + 32'(4 * i), prog[i]);
		end
		exp_fault = ref_run();
		repeat (9) @(posedge clk);
		rst_n <= 1'b1;
		limit  = prog.size() * 40;
		cycles = 0;
		while (!(halt || fault) && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (cycles >= limit) begin
			errors++;
			timed_out = 1'b1;
			$display("Timeout: program %0d reached neither halt nor fault in %0d cycles",
				which, limit);
		end else begin
			repeat (3) @(posedge clk);
			checks += 3;
			assert (fault == exp_fault && halt == !exp_fault)
			else begin
				errors++;
				$display("Error %0t: program %0d ended with halt=%b fault=%b", $time, which,
					halt, fault);
			end
			assert (store_idx == exp_addr.size())
			else begin
				errors++;
				$display("Error %0t: program %0d made %0d stores, expected %0d", $time, which,
					store_idx, exp_addr.size());
			end
			assert (mem.size() == ref_mem.size())
			else begin
				errors++;
				$display("Error %0t: program %0d memory holds %0d words, expected %0d", $time,
					which, mem.size(), ref_mem.size());
			end
			foreach (ref_mem[a]) begin
				checks++;
				assert (mem.exists(a) && mem[a] == ref_mem[a])
				else begin
					errors++;
					$display("Error %0t: program %0d word at %h differs from %h", $time, which,
						a, ref_mem[a]);
				end
			end
		end
	endtask

	initial begin
		void'($urandom(32'h547c));
		clk       = 1'b0;
		rst_n     = 1'b0;
		mem_resp  = '0;
		slow_mem  = 1'b0;
		timed_out = 1'b0;
		store_idx = 0;
		wait_cnt  = 0;
		errors    = 0;
		checks    = 0;
		run_prog(0, 1'b0);
		run_prog(1, 1'b0);
		run_prog(2, 1'b0);
		run_prog(3, 1'b0);
		// slow memory lets fetches and data accesses interleave
		run_prog(0, 1'b1);
		run_prog(1, 1'b1);
		$display("Errors: %0d, checks: %0d", errors, checks);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: sources.f
common/core_pkg.sv
rtl/bus_arbiter.sv
frontend/frontend.sv
backend/backend.sv
mmu/mmu.sv
rtl/core.sv
test/core_checker.sv
test/tb_core.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_core -o tb_core_sim \
	&& ./obj_dir/tb_core_sim > sim.log 2>&1 \
	|| echo "simulation did not complete" >> sim.log
cat sim.log
grep -qx "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
